// ==== common/safe_lockstep_cfg.svh ====
/*
  Build constants for the three-hart safety bus front end.
  The word width must stay equal to request + write enable + address + data.
*/
`ifndef SAFE_LOCKSTEP_CFG_SVH
`define SAFE_LOCKSTEP_CFG_SVH

// Cluster size, fixed by the voter
`define SL_NHARTS 3

// Request fields
`define SL_ADDR_W 32
`define SL_DATA_W 32
`define SL_WORD_W (2 + `SL_ADDR_W + `SL_DATA_W)

// Lag of the checker hart behind the master in dual mode
`define SL_LOCKSTEP_CYCLES 2

// Test timing limits
`define SL_TB_RESET_CYCLES 8
`define SL_TB_CYCLES_PER_LINE 12

`endif

// ==== common/safe_lockstep_pkg.sv ====
/*
  Types shared by the safety bus front end.
  A request word is {req, we, addr, wdata} from the MSB down.
*/
`include "safe_lockstep_cfg.svh"

package safe_lockstep_pkg;

  // One hart request cycle, compared in full
  typedef logic [`SL_WORD_W-1:0] req_word_t;

  // Hart number 0..2, value 3 is not a hart
  typedef logic [1:0] hart_idx_t;

  // Redundancy mode of the cluster
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_TMR    = 2'd1,
    MODE_DMR    = 2'd2
  } safe_mode_e;

  // One bit per hart, used for error identity
  typedef logic [`SL_NHARTS-1:0] hart_mask_t;

endpackage

// ==== rtl/hart_router.sv ====
/*
  Holds the mode, master and checker selection, loaded by a one-cycle strobe.
  A hart index of 3 selects an all-zero word. Selection is combinational.
*/
`include "safe_lockstep_cfg.svh"

module hart_router (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic [`SL_NHARTS-1:0]                            hart_req_i,
  input  logic [`SL_NHARTS-1:0]                            hart_we_i,
  input  logic [`SL_NHARTS-1:0][`SL_ADDR_W-1:0]            hart_addr_i,
  input  logic [`SL_NHARTS-1:0][`SL_DATA_W-1:0]            hart_wdata_i,
  input  logic                                             cfg_load_i,
  input  safe_lockstep_pkg::safe_mode_e                    cfg_mode_i,
  input  safe_lockstep_pkg::hart_idx_t                     cfg_master_i,
  input  safe_lockstep_pkg::hart_idx_t                     cfg_checker_i,
  output safe_lockstep_pkg::safe_mode_e                    mode_o,
  output safe_lockstep_pkg::req_word_t [`SL_NHARTS-1:0]    hart_word_o,
  output safe_lockstep_pkg::req_word_t                     master_word_o,
  output safe_lockstep_pkg::req_word_t                     checker_word_o,
  output logic                                             shift_en_o,
  output logic                                             flush_o
);
  import safe_lockstep_pkg::*;

  localparam hart_idx_t LastHart = hart_idx_t'(`SL_NHARTS - 1);

  safe_mode_e mode_q;
  hart_idx_t  master_q;
  hart_idx_t  checker_q;

  // Configuration register, defaults to single mode on hart 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= MODE_SINGLE;
      master_q  <= hart_idx_t'(0);
      checker_q <= hart_idx_t'(1);
    end else if (cfg_load_i) begin
      mode_q    <= cfg_mode_i;
      master_q  <= cfg_master_i;
      checker_q <= cfg_checker_i;
    end
  end

  // Pack each hart's fields into one request word
  always_comb begin
    for (int i = 0; i < `SL_NHARTS; i++) begin
      hart_word_o[i] = {hart_req_i[i], hart_we_i[i], hart_addr_i[i], hart_wdata_i[i]};
    end
  end

  // Master and checker streams by index
  always_comb begin
    master_word_o  = '0;
    checker_word_o = '0;
    if (master_q <= LastHart) begin
      master_word_o = hart_word_o[master_q];
    end
    if (checker_q <= LastHart) begin
      checker_word_o = hart_word_o[checker_q];
    end
  end

  assign mode_o = mode_q;

  // Delay line only advances in dual mode
  assign shift_en_o = (mode_q == MODE_DMR);

  // Words in flight belong to the old configuration, drop them at the load edge
  assign flush_o = cfg_load_i;

endmodule

// ==== rtl/lockstep_delay.sv ====
/*
  Delay line for the master request word, SL_LOCKSTEP_CYCLES deep.
  Latency is exact only while shift_en_i is held. Flush wins over shift.
*/
`include "safe_lockstep_cfg.svh"

module lockstep_delay (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  safe_lockstep_pkg::req_word_t word_i,
  input  logic                         shift_en_i,
  input  logic                         flush_i,
  output safe_lockstep_pkg::req_word_t word_o
);
  import safe_lockstep_pkg::*;

  localparam int unsigned Depth = `SL_LOCKSTEP_CYCLES;

  req_word_t line_q [Depth];

  // Stage 0 takes the master word, each later stage the one before it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        line_q[i] <= '0;
      end
    end else if (flush_i) begin
      // Cleared so no request bit survives a mode change
      for (int i = 0; i < Depth; i++) begin
        line_q[i] <= '0;
      end
    end else if (shift_en_i) begin
      line_q[0] <= word_i;
      for (int i = 1; i < Depth; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  // Oldest stage lines up with the checker hart
  assign word_o = line_q[Depth-1];

endmodule

// ==== rtl/redundancy_checker/redundancy_checker.sv ====
/*
  Votes, compares and drives the system bus one cycle after its inputs.
  Error pulses only in the mode that owns them. The third hart is
  ignored in dual mode.
*/
`include "safe_lockstep_cfg.svh"

module redundancy_checker (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  safe_lockstep_pkg::safe_mode_e                  mode_i,
  input  safe_lockstep_pkg::req_word_t [`SL_NHARTS-1:0]  hart_word_i,
  input  safe_lockstep_pkg::req_word_t                   master_word_i,
  input  safe_lockstep_pkg::req_word_t                   checker_word_i,
  input  safe_lockstep_pkg::req_word_t                   delayed_word_i,
  output logic                                           bus_req_o,
  output logic                                           bus_we_o,
  output logic [`SL_ADDR_W-1:0]                          bus_addr_o,
  output logic [`SL_DATA_W-1:0]                          bus_wdata_o,
  output logic                                           tmr_error_o,
  output safe_lockstep_pkg::hart_mask_t                  tmr_error_id_o,
  output logic                                           dmr_error_o
);
  import safe_lockstep_pkg::*;

  // Bit positions inside a request word
  localparam int unsigned ReqBit = `SL_WORD_W - 1;
  localparam int unsigned WeBit  = `SL_WORD_W - 2;
  localparam int unsigned AddrLo = `SL_DATA_W;
  localparam int unsigned AddrHi = `SL_DATA_W + `SL_ADDR_W - 1;

  req_word_t  voted_word;
  hart_mask_t disagree_mask;
  logic       dmr_mismatch;
  req_word_t  bus_word;
  logic       tmr_error_d;
  hart_mask_t tmr_error_id_d;
  logic       dmr_error_d;

  // Bitwise two-out-of-three majority
  assign voted_word = (hart_word_i[0] & hart_word_i[1]) |
                      (hart_word_i[0] & hart_word_i[2]) |
                      (hart_word_i[1] & hart_word_i[2]);

  // A hart disagrees if any bit differs from the majority
  always_comb begin
    for (int i = 0; i < `SL_NHARTS; i++) begin
      disagree_mask[i] = |(hart_word_i[i] ^ voted_word);
    end
  end

  // Delayed master against the late checker, request bit included
  assign dmr_mismatch = (delayed_word_i != checker_word_i);

  // Bus word and error sources by mode
  always_comb begin
    bus_word       = '0;
    tmr_error_d    = 1'b0;
    tmr_error_id_d = '0;
    dmr_error_d    = 1'b0;
    unique case (mode_i)
      MODE_SINGLE: begin
        bus_word = master_word_i;
      end
      MODE_TMR: begin
        bus_word       = voted_word;
        tmr_error_d    = |disagree_mask;
        tmr_error_id_d = disagree_mask;
      end
      MODE_DMR: begin
        // Master word goes out even on a mismatch, the flag reports it
        bus_word    = delayed_word_i;
        dmr_error_d = dmr_mismatch;
      end
      default: begin
        bus_word = '0;
      end
    endcase
  end

  // Strobe and error pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_req_o      <= 1'b0;
      tmr_error_o    <= 1'b0;
      tmr_error_id_o <= '0;
      dmr_error_o    <= 1'b0;
    end else begin
      bus_req_o      <= bus_word[ReqBit];
      tmr_error_o    <= tmr_error_d;
      tmr_error_id_o <= tmr_error_id_d;
      dmr_error_o    <= dmr_error_d;
    end
  end

  // Payload, only meaningful while bus_req_o is high
  always_ff @(posedge clk_i) begin
    bus_we_o    <= bus_word[WeBit];
    bus_addr_o  <= bus_word[AddrHi:AddrLo];
    bus_wdata_o <= bus_word[`SL_DATA_W-1:0];
  end

endmodule

// ==== rtl/safe_lockstep_top.sv ====
/*
  Safety bus front end for a three-hart cluster. Requests are one-cycle
  strobes with no back-pressure, and no response path exists.
  Bus word latency is 1 cycle, or 3 cycles from the master in dual mode.
*/
`include "safe_lockstep_cfg.svh"

module safe_lockstep_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Per hart request fields
  input  logic [`SL_NHARTS-1:0]                      hart_req_i,
  input  logic [`SL_NHARTS-1:0]                      hart_we_i,
  input  logic [`SL_NHARTS-1:0][`SL_ADDR_W-1:0]      hart_addr_i,
  input  logic [`SL_NHARTS-1:0][`SL_DATA_W-1:0]      hart_wdata_i,
  // Configuration load
  input  logic                                       cfg_load_i,
  input  safe_lockstep_pkg::safe_mode_e              cfg_mode_i,
  input  safe_lockstep_pkg::hart_idx_t               cfg_master_i,
  input  safe_lockstep_pkg::hart_idx_t               cfg_checker_i,
  // System bus request
  output logic                                       bus_req_o,
  output logic                                       bus_we_o,
  output logic [`SL_ADDR_W-1:0]                      bus_addr_o,
  output logic [`SL_DATA_W-1:0]                      bus_wdata_o,
  // Error reporting
  output logic                                       tmr_error_o,
  output safe_lockstep_pkg::hart_mask_t              tmr_error_id_o,
  output logic                                       dmr_error_o
);
  import safe_lockstep_pkg::*;

  safe_mode_e                  mode;
  req_word_t [`SL_NHARTS-1:0]  hart_word;
  req_word_t                   master_word;
  req_word_t                   checker_word;
  req_word_t                   delayed_word;
  logic                        shift_en;
  logic                        flush;

  hart_router u_router (
    .clk_i,
    .rst_ni,
    .hart_req_i,
    .hart_we_i,
    .hart_addr_i,
    .hart_wdata_i,
    .cfg_load_i,
    .cfg_mode_i,
    .cfg_master_i,
    .cfg_checker_i,
    .mode_o         (mode),
    .hart_word_o    (hart_word),
    .master_word_o  (master_word),
    .checker_word_o (checker_word),
    .shift_en_o     (shift_en),
    .flush_o        (flush)
  );

  // Master runs ahead of the checker through this line
  lockstep_delay u_delay (
    .clk_i,
    .rst_ni,
    .word_i     (master_word),
    .shift_en_i (shift_en),
    .flush_i    (flush),
    .word_o     (delayed_word)
  );

  redundancy_checker u_checker (
    .clk_i,
    .rst_ni,
    .mode_i         (mode),
    .hart_word_i    (hart_word),
    .master_word_i  (master_word),
    .checker_word_i (checker_word),
    .delayed_word_i (delayed_word),
    .bus_req_o,
    .bus_we_o,
    .bus_addr_o,
    .bus_wdata_o,
    .tmr_error_o,
    .tmr_error_id_o,
    .dmr_error_o
  );

endmodule

// ==== tb/tb_safe_lockstep.sv ====
/*
  Testbench for the safety bus front end, driven by the stimulus file.
  Lines of one test share an 8-cycle window after an optional config load.
  Results due after the window are not claimed, so the bus must stay idle.
*/
`include "safe_lockstep_cfg.svh"

module tb_safe_lockstep;
  import safe_lockstep_pkg::*;

  localparam int        ClkPeriod = 8;
  localparam int        Window    = 8;
  localparam int        MaxLines  = 64;
  localparam string     StimFile  = "tb/safe_lockstep_stimulus.txt";
  localparam req_word_t RandMark  = '1;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic [`SL_NHARTS-1:0]                 hart_req_i;
  logic [`SL_NHARTS-1:0]                 hart_we_i;
  logic [`SL_NHARTS-1:0][`SL_ADDR_W-1:0] hart_addr_i;
  logic [`SL_NHARTS-1:0][`SL_DATA_W-1:0] hart_wdata_i;
  logic                                  cfg_load_i;
  safe_mode_e                            cfg_mode_i;
  hart_idx_t                             cfg_master_i;
  hart_idx_t                             cfg_checker_i;
  logic                                  bus_req_o;
  logic                                  bus_we_o;
  logic [`SL_ADDR_W-1:0]                 bus_addr_o;
  logic [`SL_DATA_W-1:0]                 bus_wdata_o;
  logic                                  tmr_error_o;
  hart_mask_t                            tmr_error_id_o;
  logic                                  dmr_error_o;

  // Stimulus table, one entry per file line
  int         line_test    [MaxLines];
  int         line_mode    [MaxLines];
  int         line_master  [MaxLines];
  int         line_checker [MaxLines];
  int         line_off     [MaxLines][`SL_NHARTS];
  req_word_t  line_word    [MaxLines][`SL_NHARTS];
  req_word_t  line_exp     [MaxLines];
  logic       line_tmr     [MaxLines];
  hart_mask_t line_mask    [MaxLines];
  logic       line_dmr     [MaxLines];

  int n_lines;
  int seed;
  int errors;
  int checks;
  int tests;
  int cur_mode;
  int cur_master;
  int cur_checker;
  bit loaded;

  safe_lockstep_top dut (
    .clk_i,
    .rst_ni,
    .hart_req_i,
    .hart_we_i,
    .hart_addr_i,
    .hart_wdata_i,
    .cfg_load_i,
    .cfg_mode_i,
    .cfg_master_i,
    .cfg_checker_i,
    .bus_req_o,
    .bus_we_o,
    .bus_addr_o,
    .bus_wdata_o,
    .tmr_error_o,
    .tmr_error_id_o,
    .dmr_error_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_word(input string name, input req_word_t act, input req_word_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_mask(input string name, input hart_mask_t act, input hart_mask_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic read_stimulus();
    int        fd;
    int        cnt;
    string     text;
    int        tn, md, ms, ck;
    int        o0, o1, o2;
    req_word_t w0, w1, w2, ew;
    int        et, em, ed;
    n_lines = 0;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", StimFile);
      errors++;
      return;
    end
    while (!$feof(fd) && n_lines < MaxLines) begin
      text = "";
      void'($fgets(text, fd));
      if (text.len() < 2 || text.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(text, "%d %d %d %d %h %h %h %h %h %h %h %h %h %h",
                    tn, md, ms, ck, o0, o1, o2, w0, w1, w2, ew, et, em, ed);
      if (cnt != 14) begin
        $display("Stimulus line could not be parsed: %s", text);
        errors++;
        continue;
      end
      line_test[n_lines]    = tn;
      line_mode[n_lines]    = md;
      line_master[n_lines]  = ms;
      line_checker[n_lines] = ck;
      line_off[n_lines][0]  = o0;
      line_off[n_lines][1]  = o1;
      line_off[n_lines][2]  = o2;
      line_word[n_lines][0] = w0;
      line_word[n_lines][1] = w1;
      line_word[n_lines][2] = w2;
      line_exp[n_lines]     = ew;
      line_tmr[n_lines]     = et[0];
      line_mask[n_lines]    = hart_mask_t'(em);
      line_dmr[n_lines]     = ed[0];
      n_lines++;
    end
    $fclose(fd);
  endtask

  // Valid request with random write enable, address and data
  function automatic req_word_t random_word();
    logic [31:0]           ctrl;
    logic [`SL_ADDR_W-1:0] addr;
    logic [`SL_DATA_W-1:0] data;
    ctrl = $random(seed);
    addr = $random(seed);
    data = $random(seed);
    return {1'b1, ctrl[0], addr, data};
  endfunction

  task automatic fill_random(input int i);
    req_word_t rnd;
    int        h;
    rnd = random_word();
    for (h = 0; h < `SL_NHARTS; h++) begin
      if (line_word[i][h] == RandMark) begin
        line_word[i][h] = rnd;
      end
    end
    if (line_exp[i] == RandMark) begin
      line_exp[i] = rnd;
    end
  endtask

  task automatic idle_harts();
    hart_req_i   = '0;
    hart_we_i    = '0;
    hart_addr_i  = '0;
    hart_wdata_i = '0;
  endtask

  // One load cycle, harts idle
  task automatic apply_config(input int i);
    @(posedge clk_i);
    #1;
    check_cycle(-1);
    idle_harts();
    cfg_load_i    = 1'b1;
    cfg_mode_i    = safe_mode_e'(line_mode[i]);
    cfg_master_i  = hart_idx_t'(line_master[i]);
    cfg_checker_i = hart_idx_t'(line_checker[i]);
    cur_mode      = line_mode[i];
    cur_master    = line_master[i];
    cur_checker   = line_checker[i];
  endtask

  task automatic drive_harts(input int first, input int last, input int j);
    req_word_t word [`SL_NHARTS];
    int        i;
    int        h;
    for (h = 0; h < `SL_NHARTS; h++) begin
      word[h] = '0;
    end
    for (i = first; i <= last; i++) begin
      for (h = 0; h < `SL_NHARTS; h++) begin
        if (line_off[i][h] == j) begin
          word[h] = line_word[i][h];
        end
      end
    end
    cfg_load_i = 1'b0;
    for (h = 0; h < `SL_NHARTS; h++) begin
      {hart_req_i[h], hart_we_i[h], hart_addr_i[h], hart_wdata_i[h]} = word[h];
    end
  endtask

  // Unclaimed cycles expect an idle bus and no error pulse
  task automatic check_cycle(input int idx);
    logic       exp_tmr;
    hart_mask_t exp_mask;
    logic       exp_dmr;
    exp_tmr  = 1'b0;
    exp_mask = '0;
    exp_dmr  = 1'b0;
    if (idx >= 0) begin
      exp_tmr  = line_tmr[idx];
      exp_mask = line_mask[idx];
      exp_dmr  = line_dmr[idx];
      check_word("{bus_req_o, bus_we_o, bus_addr_o, bus_wdata_o}",
                 {bus_req_o, bus_we_o, bus_addr_o, bus_wdata_o}, line_exp[idx]);
    end else begin
      check_flag("bus_req_o", bus_req_o, 1'b0);
    end
    check_flag("tmr_error_o", tmr_error_o, exp_tmr);
    check_mask("tmr_error_id_o", tmr_error_id_o, exp_mask);
    check_flag("dmr_error_o", dmr_error_o, exp_dmr);
  endtask

  task automatic run_test(input int first, input int last);
    int claim [Window];
    int errors_before;
    int lat;
    int chk;
    int i;
    int j;
    errors_before = errors;
    for (j = 0; j < Window; j++) begin
      claim[j] = -1;
    end
    for (i = first; i <= last; i++) begin
      fill_random(i);
      if (line_mode[i] != line_mode[first] || line_master[i] != line_master[first] ||
          line_checker[i] != line_checker[first]) begin
        $display("Test %0d changes its configuration inside the test", line_test[first]);
        errors++;
      end
    end
    if (line_mode[first] != cur_mode || line_master[first] != cur_master ||
        line_checker[first] != cur_checker) begin
      apply_config(first);
    end
    // Dual mode adds the lockstep lag in front of the registered output
    lat = (line_mode[first] == int'(MODE_DMR)) ? 1 + `SL_LOCKSTEP_CYCLES : 1;
    for (i = first; i <= last; i++) begin
      chk = line_off[i][line_master[i]] + lat;
      if (chk < Window) begin
        claim[chk] = i;
      end
    end
    for (j = 0; j < Window; j++) begin
      @(posedge clk_i);
      #1;
      check_cycle(claim[j]);
      drive_harts(first, last, j);
    end
    tests++;
    $display("Test %0d done: %0d lines, %0d errors", line_test[first],
             last - first + 1, errors - errors_before);
  endtask

  initial begin : main
    int first;
    int last;
    rst_ni        = 1'b0;
    cfg_load_i    = 1'b0;
    cfg_mode_i    = MODE_SINGLE;
    cfg_master_i  = hart_idx_t'(0);
    cfg_checker_i = hart_idx_t'(1);
    idle_harts();
    seed        = 32'hf6b04c4e;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    cur_mode    = int'(MODE_SINGLE);
    cur_master  = 0;
    cur_checker = 1;
    read_stimulus();
    loaded = 1'b1;
    repeat (`SL_TB_RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    first = 0;
    while (first < n_lines) begin
      last = first;
      while (last + 1 < n_lines && line_test[last + 1] == line_test[first]) begin
        last++;
      end
      run_test(first, last);
      first = last + 1;
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Each line costs at most one load cycle plus one window
  initial begin : watchdog
    wait (loaded);
    #((n_lines * `SL_TB_CYCLES_PER_LINE + `SL_TB_RESET_CYCLES) * ClkPeriod);
    $display("Timeout: the run did not finish %0d stimulus lines in time", n_lines);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== safe_lockstep.f ====
+incdir+common
common/safe_lockstep_pkg.sv
rtl/hart_router.sv
rtl/lockstep_delay.sv
rtl/redundancy_checker/redundancy_checker.sv
rtl/safe_lockstep_top.sv
tb/tb_safe_lockstep.sv

// ==== tb/safe_lockstep_stimulus.txt ====
# test mode master checker off0 off1 off2 word0 word1 word2 exp_word exp_tmr exp_mask exp_dmr
# Modes 0 single, 1 triple, 2 dual. Offsets count cycles from the test start, f never issues.
# Words are {req, we, addr, wdata} in hex. 3ffffffffffffffff is one random word per line.
# Lines with one test number share a window. A result past the window must never appear.
1 0 2 1 0 f 0 20000200000000000 0 300001000deadbeef 300001000deadbeef 0 0 0
1 0 2 1 f f 3 0 0 3ffffffffffffffff 3ffffffffffffffff 0 0 0
2 1 0 1 0 0 0 30000004012345678 30000004012345678 30000004012345678 30000004012345678 0 0 0
2 1 0 1 3 3 3 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 0 0 0
3 1 0 1 0 0 0 20000008000000000 20000018000000000 20000008000000000 20000008000000000 1 2 0
3 1 0 1 3 3 3 30000010000000001 30000010000000000 30000010000000000 30000010000000000 1 1 0
3 1 0 1 5 5 f 300000140000000aa 300000140000000aa 0 300000140000000aa 1 4 0
4 2 0 2 0 0 2 300000200cafef00d 30000ffff0000ffff 300000200cafef00d 300000200cafef00d 0 0 0
4 2 0 2 1 f 3 20000020400000000 0 20000020400000000 20000020400000000 0 0 0
4 2 0 2 4 f 6 3ffffffffffffffff 0 3ffffffffffffffff 3ffffffffffffffff 0 0 0
5 2 0 2 0 f 2 30000030000000011 0 30000030000000012 30000030000000011 0 0 1
5 2 0 2 3 f f 20000030400000000 0 0 20000030400000000 0 0 1
6 2 0 2 0 f 2 30000040011111111 0 30000040011111111 30000040011111111 0 0 0
6 2 0 2 7 f f 3000005005a5a5a5a 0 0 0 0 0 0
7 0 1 0 0 0 f 30000060076543210 20000060400000000 0 20000060400000000 0 0 0
8 1 0 1 1 1 1 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 0 0 0
8 1 0 1 4 4 4 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 3ffffffffffffffff 0 0 0
9 0 0 1 0 f f 3ffffffffffffffff 0 0 3ffffffffffffffff 0 0 0
9 0 0 1 2 f f 3ffffffffffffffff 0 0 3ffffffffffffffff 0 0 0
10 2 1 0 2 0 f 3ffffffffffffffff 3ffffffffffffffff 0 3ffffffffffffffff 0 0 0
